// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_axi2avmm
FILELIST := filelist.f
BUILD    := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the status line"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(BUILD)

// File: axi2avmm_bridge.sv
// ================================================
// axi4 to avmm bridge, single channel
// one write or one read command per cycle toward
// the memory controller, write wins on a tie,
// in order read returns matched to queued arids
// ================================================

`timescale 1ns/1ns

module axi2avmm_bridge (
  input  logic               ip_clk,
  input  logic               ip_rst_n,  // sync, active low

  // ================================================
  // axi write address and data
  // ================================================
  input  logic               i_awvalid,
  input  br_pkg::axi_addr_t  i_awaddr,
  input  br_pkg::axi_id_t    i_awid,
  output logic               o_awready,
  input  logic               i_wvalid,
  input  br_pkg::data_t      i_wdata,
  input  br_pkg::strb_t      i_wstrb,
  input  logic               i_wpoison,
  output logic               o_wready,

  // axi read address
  input  logic               i_arvalid,
  input  br_pkg::axi_addr_t  i_araddr,
  input  br_pkg::axi_id_t    i_arid,
  output logic               o_arready,

  // axi responses, always okay
  output logic               o_bvalid,
  output br_pkg::axi_id_t    o_bid,
  output logic               o_rvalid,
  output br_pkg::axi_id_t    o_rid,
  output br_pkg::data_t      o_rdata,
  output logic               o_rpoison,

  // ================================================
  // memory controller command port
  // ================================================
  output logic               o_avmm_write,
  output logic               o_avmm_read,
  output br_pkg::mc_addr_t   o_avmm_address,
  output br_pkg::data_t      o_avmm_writedata,
  output br_pkg::strb_t      o_avmm_byteenable,
  output logic               o_avmm_write_poison,
  input  logic               i_avmm_ready,
  input  logic               i_avmm_readdatavalid,
  input  br_pkg::data_t      i_avmm_readdata,
  input  logic               i_avmm_read_poison
);

  logic wr_accept;  // write command this cycle
  logic rd_accept;  // read command this cycle
  logic rd_room;    // id queue can take another read

  br_req_arb u_req_arb (
    .i_awvalid           (i_awvalid),
    .i_awaddr            (i_awaddr),
    .i_wvalid            (i_wvalid),
    .i_wdata             (i_wdata),
    .i_wstrb             (i_wstrb),
    .i_wpoison           (i_wpoison),
    .i_arvalid           (i_arvalid),
    .i_araddr            (i_araddr),
    .i_avmm_ready        (i_avmm_ready),
    .i_rd_room           (rd_room),
    .o_awready           (o_awready),
    .o_wready            (o_wready),
    .o_arready           (o_arready),
    .o_wr_accept         (wr_accept),
    .o_rd_accept         (rd_accept),
    .o_avmm_write        (o_avmm_write),
    .o_avmm_read         (o_avmm_read),
    .o_avmm_address      (o_avmm_address),
    .o_avmm_writedata    (o_avmm_writedata),
    .o_avmm_byteenable   (o_avmm_byteenable),
    .o_avmm_write_poison (o_avmm_write_poison)
  );

  // bresp one cycle after the write command
  br_wr_path u_wr_path (
    .ip_clk      (ip_clk),
    .ip_rst_n    (ip_rst_n),
    .i_wr_accept (wr_accept),
    .i_awid      (i_awid),
    .o_bvalid    (o_bvalid),
    .o_bid       (o_bid)
  );

  br_rd_path u_rd_path (
    .ip_clk               (ip_clk),
    .ip_rst_n             (ip_rst_n),
    .i_rd_accept          (rd_accept),
    .i_arid               (i_arid),
    .i_avmm_readdatavalid (i_avmm_readdatavalid),
    .i_avmm_readdata      (i_avmm_readdata),
    .i_avmm_read_poison   (i_avmm_read_poison),
    .o_rd_room            (rd_room),
    .o_rvalid             (o_rvalid),
    .o_rid                (o_rid),
    .o_rdata              (o_rdata),
    .o_rpoison            (o_rpoison)
  );

endmodule

// File: br_config.svh
// ================================================
// bridge configuration macros
// widths, controller address slice and the
// read id queue depth with its stall threshold
// ================================================

`ifndef BR_CONFIG_SVH
`define BR_CONFIG_SVH

// data path
`define BR_DATA_W      64                // axi and controller data beat
`define BR_STRB_W      (`BR_DATA_W / 8)  // one enable per byte

// addressing
`define BR_AXI_ADDR_W  32  // axi byte address
`define BR_ADDR_LSB    3   // drop byte offset inside a 64 bit word
`define BR_ADDR_MSB    30  // top address bit passed to the controller

// transaction ids
`define BR_ID_W        8

// read id queue
`define BR_RDID_DEPTH  16  // max reads in flight at the controller

// arready drops at this fill level
// two entries of slack below full
`define BR_RDID_AFULL  14

`endif

// File: br_pkg.sv
// ================================================
// bridge types
// plain vector typedefs shared by the rtl blocks
// and the testbench
// ================================================

`include "br_config.svh"

package br_pkg;

  // ================================================
  // axi side
  // ================================================
  typedef logic [`BR_AXI_ADDR_W-1:0] axi_addr_t;  // byte address
  typedef logic [`BR_ID_W-1:0]       axi_id_t;    // awid / arid / bid / rid

  // ================================================
  // shared payload
  // ================================================
  typedef logic [`BR_DATA_W-1:0] data_t;  // one beat
  typedef logic [`BR_STRB_W-1:0] strb_t;  // byte enables

  // ================================================
  // controller side
  // ================================================
  // word address, keeps the original bit positions of the axi address
  typedef logic [`BR_ADDR_MSB:`BR_ADDR_LSB] mc_addr_t;

  // queue fill level, must reach the full depth value itself
  typedef logic [$clog2(`BR_RDID_DEPTH + 1)-1:0] rdid_cnt_t;

endpackage

// File: br_rd_path.sv
// ================================================
// read response path
// queues arids in issue order and pairs each
// returned controller beat with the oldest id
// ================================================

`timescale 1ns/1ns

module br_rd_path (
  input  logic             ip_clk,
  input  logic             ip_rst_n,
  input  logic             i_rd_accept,           // read command issued
  input  br_pkg::axi_id_t  i_arid,
  input  logic             i_avmm_readdatavalid,  // in order beat from mc
  input  br_pkg::data_t    i_avmm_readdata,
  input  logic             i_avmm_read_poison,
  output logic             o_rd_room,             // gates arready
  output logic             o_rvalid,
  output br_pkg::axi_id_t  o_rid,
  output br_pkg::data_t    o_rdata,
  output logic             o_rpoison
);

  br_pkg::axi_id_t   head_id;   // oldest outstanding arid
  br_pkg::rdid_cnt_t rd_count;  // reads in flight

  // ================================================
  // id queue
  // ================================================
  br_rdid_fifo u_rdid_fifo (
    .ip_clk   (ip_clk),
    .ip_rst_n (ip_rst_n),
    .i_push   (i_rd_accept),
    .i_pop    (i_avmm_readdatavalid),  // one beat retires one id
    .i_din    (i_arid),
    .o_dout   (head_id),
    .o_count  (rd_count),
    .o_room   (o_rd_room)
  );

  // ================================================
  // response mapping
  // ================================================
  // controller returns in order so no id search is needed
  always_comb
  begin
    o_rvalid  = i_avmm_readdatavalid;  // rready ignored
    o_rid     = head_id;
    o_rdata   = i_avmm_readdata;
    o_rpoison = i_avmm_readdatavalid & i_avmm_read_poison;  // only meaningful with a beat
  end

  // a beat with nothing outstanding means the controller
  // returned more data than reads were issued
  a_beat_has_id: assert property (@(posedge ip_clk) disable iff (!ip_rst_n)
    i_avmm_readdatavalid |-> (rd_count != '0));

endmodule

// File: br_rdid_fifo.sv
// ================================================
// read id queue
// register array fifo with show-ahead head output,
// fill count and an early room flag for arready
// ================================================

`timescale 1ns/1ns

`include "br_config.svh"

module br_rdid_fifo (
  input  logic                ip_clk,
  input  logic                ip_rst_n,
  input  logic                i_push,   // arid accepted
  input  logic                i_pop,    // read beat returned
  input  br_pkg::axi_id_t     i_din,
  output br_pkg::axi_id_t     o_dout,   // head entry, valid while count > 0
  output br_pkg::rdid_cnt_t   o_count,
  output logic                o_room    // below the stall threshold
);

  localparam int DEPTH = `BR_RDID_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  br_pkg::axi_id_t  mem [DEPTH];  // id storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  // wrap at depth so a non power of two depth still works
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1))
    begin
      nxt = '0;
    end
    else
    begin
      nxt = ptr + PTR_W'(1);
    end
    return nxt;
  endfunction

  // ================================================
  // storage and pointers
  // ================================================
  always_ff @(posedge ip_clk)
  begin
    if (i_push)
    begin
      mem[wr_ptr] <= i_din;
    end
  end

  always_ff @(posedge ip_clk)
  begin
    if (!ip_rst_n)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      o_count <= '0;
    end
    else
    begin
      if (i_push) wr_ptr <= ptr_inc(wr_ptr);
      if (i_pop)  rd_ptr <= ptr_inc(rd_ptr);
      case ({i_push, i_pop})
        2'b10:   o_count <= o_count + br_pkg::rdid_cnt_t'(1);
        2'b01:   o_count <= o_count - br_pkg::rdid_cnt_t'(1);
        default: o_count <= o_count;  // idle or push and pop together
      endcase
    end
  end

  assign o_dout = mem[rd_ptr];  // show-ahead, no read latency
  assign o_room = (o_count < br_pkg::rdid_cnt_t'(`BR_RDID_AFULL));

  // arbiter threshold must keep pushes away from a full queue
  a_no_push_full: assert property (@(posedge ip_clk) disable iff (!ip_rst_n)
    i_push |-> (o_count < br_pkg::rdid_cnt_t'(DEPTH)));
  a_no_pop_empty: assert property (@(posedge ip_clk) disable iff (!ip_rst_n)
    i_pop |-> (o_count != '0));

endmodule

// File: br_req_arb.sv
// ================================================
// request arbiter
// builds awready/wready/arready, picks write over
// read and drives a single controller command
// ================================================

`timescale 1ns/1ns

`include "br_config.svh"

module br_req_arb (
  input  logic               i_awvalid,
  input  br_pkg::axi_addr_t  i_awaddr,
  input  logic               i_wvalid,
  input  br_pkg::data_t      i_wdata,
  input  br_pkg::strb_t      i_wstrb,
  input  logic               i_wpoison,
  input  logic               i_arvalid,
  input  br_pkg::axi_addr_t  i_araddr,
  input  logic               i_avmm_ready,   // controller can take a command
  input  logic               i_rd_room,      // id queue below threshold
  output logic               o_awready,
  output logic               o_wready,
  output logic               o_arready,
  output logic               o_wr_accept,    // to write path
  output logic               o_rd_accept,    // to read path
  output logic               o_avmm_write,
  output logic               o_avmm_read,
  output br_pkg::mc_addr_t   o_avmm_address,
  output br_pkg::data_t      o_avmm_writedata,
  output br_pkg::strb_t      o_avmm_byteenable,
  output logic               o_avmm_write_poison
);

  logic wr_offer;  // address and data presented together

  // ================================================
  // ready generation
  // ================================================
  assign wr_offer  = i_awvalid & i_wvalid;
  assign o_awready = i_avmm_ready;  // writes only wait on the controller
  assign o_wready  = i_avmm_ready;
  // a pending write holds the read off so it is never dropped
  assign o_arready = i_avmm_ready & i_rd_room & ~wr_offer;

  assign o_wr_accept = wr_offer & i_avmm_ready;
  assign o_rd_accept = i_arvalid & o_arready;

  // ================================================
  // command mux
  // ================================================
  always_comb
  begin
    o_avmm_write        = o_wr_accept;
    o_avmm_read         = o_rd_accept;
    o_avmm_address      = '0;
    o_avmm_writedata    = '0;  // quiet payload when idle or reading
    o_avmm_byteenable   = '0;
    o_avmm_write_poison = 1'b0;
    if (o_wr_accept)
    begin
      o_avmm_address      = i_awaddr[`BR_ADDR_MSB:`BR_ADDR_LSB];
      o_avmm_writedata    = i_wdata;
      o_avmm_byteenable   = i_wstrb;
      o_avmm_write_poison = i_wpoison;  // only user bit kept
    end
    else if (o_rd_accept)
    begin
      o_avmm_address = i_araddr[`BR_ADDR_MSB:`BR_ADDR_LSB];
    end
  end

  // one command per cycle on the controller port
  always_comb
  begin
    a_one_cmd: assert (!(o_avmm_write && o_avmm_read));
  end

endmodule

// File: br_wr_path.sv
// ================================================
// write response path
// stages the accepted awid and raises bvalid for
// one cycle starting one clock after the write command
// ================================================

`timescale 1ns/1ns

module br_wr_path (
  input  logic             ip_clk,
  input  logic             ip_rst_n,
  input  logic             i_wr_accept,  // write command issued this cycle
  input  br_pkg::axi_id_t  i_awid,
  output logic             o_bvalid,
  output br_pkg::axi_id_t  o_bid
);

  // ================================================
  // id staging
  // ================================================
  // loaded only on acceptance so bid keeps the last
  // write id while no write is in flight
  always_ff @(posedge ip_clk)
  begin
    if (i_wr_accept)
    begin
      o_bid <= i_awid;
    end
  end

  // ================================================
  // response pulse
  // ================================================
  always_ff @(posedge ip_clk)
  begin
    if (!ip_rst_n)
    begin
      o_bvalid <= 1'b0;
    end
    else
    begin
      o_bvalid <= i_wr_accept;  // bready ignored so the master must take it
    end
  end

  // back to back bvalid needs a new write each cycle
  a_bvalid_single: assert property (@(posedge ip_clk) disable iff (!ip_rst_n)
    (o_bvalid && !i_wr_accept) |=> !o_bvalid);

endmodule

// File: filelist.f
+incdir+.
br_pkg.sv
br_rdid_fifo.sv
br_wr_path.sv
br_rd_path.sv
br_req_arb.sv
axi2avmm_bridge.sv
tb_axi2avmm.sv

// File: tb_axi2avmm.sv
// ================================================
// testbench for the axi4 to avmm bridge
// random axi master and memory controller model,
// every cycle checked against a reference model
// ================================================

`timescale 1ns/1ns

`include "br_config.svh"

module tb_axi2avmm;

  localparam int N_WR    = 150;  // random phase writes
  localparam int N_RD    = 150;  // random phase reads
  localparam int N_FILL  = 20;   // reads pushed against the queue limit
  localparam int TIMEOUT = 20 * (N_WR + N_RD + N_FILL);

  // ================================================
  // dut ports, inputs start at a known value
  // ================================================
  logic              ip_clk = 1'b0;
  logic              ip_rst_n = 1'b0;
  logic              i_awvalid = 1'b0;
  br_pkg::axi_addr_t i_awaddr = '0;
  br_pkg::axi_id_t   i_awid = '0;
  logic              i_wvalid = 1'b0;
  br_pkg::data_t     i_wdata = '0;
  br_pkg::strb_t     i_wstrb = '0;
  logic              i_wpoison = 1'b0;
  logic              i_arvalid = 1'b0;
  br_pkg::axi_addr_t i_araddr = '0;
  br_pkg::axi_id_t   i_arid = '0;
  logic              i_avmm_ready = 1'b0;
  logic              i_avmm_readdatavalid = 1'b0;
  br_pkg::data_t     i_avmm_readdata = '0;
  logic              i_avmm_read_poison = 1'b0;
  logic              o_awready;
  logic              o_wready;
  logic              o_arready;
  logic              o_bvalid;
  br_pkg::axi_id_t   o_bid;
  logic              o_rvalid;
  br_pkg::axi_id_t   o_rid;
  br_pkg::data_t     o_rdata;
  logic              o_rpoison;
  logic              o_avmm_write;
  logic              o_avmm_read;
  br_pkg::mc_addr_t  o_avmm_address;
  br_pkg::data_t     o_avmm_writedata;
  br_pkg::strb_t     o_avmm_byteenable;
  logic              o_avmm_write_poison;

  // controller and reference model state, owned by the monitor
  br_pkg::data_t   mem_model [br_pkg::mc_addr_t];  // written words only
  br_pkg::data_t   mc_rd_q[$];    // beats the controller still owes
  br_pkg::axi_id_t exp_id_q[$];   // accepted arids, oldest first
  br_pkg::data_t   exp_data_q[$];
  logic            exp_bvalid = 1'b0;
  br_pkg::axi_id_t exp_bid = '0;
  logic            wr_acc = 1'b0;  // handshakes seen at the last falling edge
  logic            rd_acc = 1'b0;
  logic            exp_ar;
  int              outstanding;
  string           tag;
  int              wr_done = 0;
  int              rd_done = 0;
  int              n_checks = 0;
  int              n_errors = 0;
  int              stall_cycles = 0;
  logic            rearm_seen = 1'b0;
  // stimulus state, owned by the driver
  int              wr_left = N_WR;
  int              rd_left = N_RD;
  int              fill_left = N_FILL;
  logic            go_rd;
  // phase control, owned by the main sequence
  logic            fill_mode = 1'b0;     // ready forced high and writes off
  logic            hold_returns = 1'b0;  // controller keeps read beats back
  int              n_end_err = 0;
  int              cycles = 0;

  axi2avmm_bridge dut (.*);

  always #10 ip_clk = ~ip_clk;

  // ================================================
  // compare helpers
  // ================================================
  task automatic record_check(input string name, input logic ok, input string e, input string a);
    n_checks++;
    if (!ok)
    begin
      n_errors++;
      $display("[ERROR] %s expected %s actual %s", name, e, a);
    end
  endtask

  task automatic check_addr(input string name, input br_pkg::mc_addr_t e,
                            input br_pkg::mc_addr_t a);
    record_check(name, a === e, $sformatf("%h", e), $sformatf("%h", a));
  endtask

  task automatic check_data(input string name, input br_pkg::data_t e, input br_pkg::data_t a);
    record_check(name, a === e, $sformatf("%h", e), $sformatf("%h", a));
  endtask

  task automatic check_strb(input string name, input br_pkg::strb_t e, input br_pkg::strb_t a);
    record_check(name, a === e, $sformatf("%h", e), $sformatf("%h", a));
  endtask

  task automatic check_id(input string name, input br_pkg::axi_id_t e,
                          input br_pkg::axi_id_t a);
    record_check(name, a === e, $sformatf("%h", e), $sformatf("%h", a));
  endtask

  task automatic check_bit(input string name, input logic e, input logic a);
    record_check(name, a === e, $sformatf("%b", e), $sformatf("%b", a));
  endtask

  // unwritten words read back a pattern built from every address bit
  function automatic br_pkg::data_t mem_read(input br_pkg::mc_addr_t a);
    br_pkg::data_t w;
    if (mem_model.exists(a))
      w = mem_model[a];
    else
      w = {a ^ 28'h5a5_c3c3, 8'h96, a};
    return w;
  endfunction

  task automatic mem_write(input br_pkg::mc_addr_t a, input br_pkg::data_t d,
                           input br_pkg::strb_t be);
    br_pkg::data_t w;
    w = mem_read(a);
    for (int b = 0; b < `BR_STRB_W; b++)
      if (be[b])
        w[b*8 +: 8] = d[b*8 +: 8];  // byte lane merge
    mem_model[a] = w;
  endtask

  // 32 word window so reads often hit written data, top bit and offset are noise
  function automatic br_pkg::axi_addr_t rand_addr();
    return {1'($urandom), 23'h12_3450, 5'($urandom), 3'($urandom)};
  endfunction

  // ================================================
  // driver, axi master and controller returns
  // ================================================
  always @(posedge ip_clk)
  begin
    if (ip_rst_n)
    begin
      i_avmm_ready <= fill_mode ? 1'b1 : ($urandom_range(3) != 0);  // ready 3 of 4
      if (!i_awvalid || wr_acc)  // aw and w stay up until taken
      begin
        if (!fill_mode && wr_left > 0 && $urandom_range(1) == 1)
        begin
          i_awvalid <= 1'b1;
          i_wvalid  <= 1'b1;
          i_awaddr  <= rand_addr();
          i_awid    <= br_pkg::axi_id_t'($urandom);
          i_wdata   <= {$urandom, $urandom};
          i_wstrb   <= br_pkg::strb_t'($urandom);
          i_wpoison <= ($urandom_range(7) == 0);
          wr_left--;
        end
        else
        begin
          i_awvalid <= 1'b0;
          i_wvalid  <= 1'b0;
        end
      end
      if (!i_arvalid || rd_acc)
      begin
        go_rd = fill_mode ? (fill_left > 0) : (rd_left > 0 && $urandom_range(1) == 1);
        i_arvalid <= go_rd;
        if (go_rd)
        begin
          i_araddr <= rand_addr();
          i_arid   <= br_pkg::axi_id_t'($urandom);
          if (fill_mode)
            fill_left--;
          else
            rd_left--;
        end
      end
      // in order beats after a random delay
      if (mc_rd_q.size() > 0 && !hold_returns && $urandom_range(2) == 0)
      begin
        i_avmm_readdatavalid <= 1'b1;
        i_avmm_readdata      <= mc_rd_q[0];
        i_avmm_read_poison   <= ($urandom_range(3) == 0);
      end
      else
      begin
        i_avmm_readdatavalid <= 1'b0;
        i_avmm_read_poison   <= 1'b0;
      end
    end
  end

  // ================================================
  // monitor, checks on the falling edge where all is settled
  // ================================================
  always @(negedge ip_clk)
  begin
    wr_acc = 1'b0;
    rd_acc = 1'b0;
    if (!ip_rst_n)
    begin
      exp_bvalid = 1'b0;
    end
    else
    begin
      outstanding = exp_id_q.size();
      exp_ar = i_avmm_ready && (outstanding < `BR_RDID_AFULL) && !(i_awvalid && i_wvalid);
      wr_acc = i_awvalid && i_wvalid && i_avmm_ready;
      rd_acc = i_arvalid && exp_ar;
      if (!i_avmm_ready)
        tag = "backpressure";
      else if (i_awvalid && i_wvalid)
        tag = "write_priority";
      else
        tag = "read_gate";
      check_bit({tag, "_awready"}, i_avmm_ready, o_awready);
      check_bit({tag, "_wready"}, i_avmm_ready, o_wready);
      check_bit({tag, "_arready"}, exp_ar, o_arready);
      check_bit({tag, "_avmm_write"}, wr_acc, o_avmm_write);
      check_bit({tag, "_avmm_read"}, rd_acc, o_avmm_read);
      if (fill_mode && i_arvalid && outstanding == `BR_RDID_AFULL && !o_arready)
        stall_cycles++;
      if (fill_mode && !hold_returns && o_arready)
        rearm_seen = 1'b1;  // room again after a beat left the queue
      if (wr_acc)
      begin
        check_addr("write_map_address", i_awaddr[`BR_ADDR_MSB:`BR_ADDR_LSB], o_avmm_address);
        check_data("write_map_data", i_wdata, o_avmm_writedata);
        check_strb("write_map_byteenable", i_wstrb, o_avmm_byteenable);
        check_bit("write_map_poison", i_wpoison, o_avmm_write_poison);
        mem_write(o_avmm_address, o_avmm_writedata, o_avmm_byteenable);
        wr_done++;
      end
      // response lags the write by exactly one cycle
      check_bit("write_resp_bvalid", exp_bvalid, o_bvalid);
      if (exp_bvalid)
        check_id("write_resp_bid", exp_bid, o_bid);
      exp_bvalid = wr_acc;
      if (wr_acc)
        exp_bid = i_awid;
      check_bit("read_order_rvalid", i_avmm_readdatavalid, o_rvalid);
      if (i_avmm_readdatavalid)
      begin
        if (outstanding == 0)
        begin
          n_errors++;
          $display("a read beat came back with no read outstanding in the model");
        end
        else
        begin
          check_id("read_order_rid", exp_id_q.pop_front(), o_rid);
          check_data("read_order_data", exp_data_q.pop_front(), o_rdata);
          check_bit("read_order_poison", i_avmm_read_poison, o_rpoison);
          void'(mc_rd_q.pop_front());
        end
        rd_done++;
      end
      if (rd_acc)
      begin
        check_addr("read_map_address", i_araddr[`BR_ADDR_MSB:`BR_ADDR_LSB], o_avmm_address);
        exp_id_q.push_back(i_arid);
        exp_data_q.push_back(mem_read(i_araddr[`BR_ADDR_MSB:`BR_ADDR_LSB]));
        mc_rd_q.push_back(mem_read(o_avmm_address));  // controller snapshot
      end
    end
  end

  // run limit from the transaction count
  always @(posedge ip_clk)
  begin
    cycles++;
    if (cycles > TIMEOUT)
    begin
      $display("timeout after %0d cycles with transactions still pending", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ================================================
  // main sequence
  // ================================================
  initial
  begin
    void'($urandom(32'he186_5db6));
    repeat (4) @(posedge ip_clk);
    ip_rst_n <= 1'b1;
    wait (wr_done == N_WR && rd_done == N_RD);  // random mix drained
    fill_mode    = 1'b1;
    hold_returns = 1'b1;
    wait (stall_cycles >= 4);  // arready held low at the limit
    hold_returns = 1'b0;
    wait (rd_done == N_RD + N_FILL);
    repeat (4) @(negedge ip_clk);
    if (exp_id_q.size() != 0 || mc_rd_q.size() != 0)
    begin
      n_end_err++;
      $display("reads were still outstanding at the end of the run");
    end
    if (!rearm_seen)
    begin
      n_end_err++;
      $display("arready never came back after the read queue drained below the limit");
    end
    $display("checks %0d errors %0d writes %0d reads %0d",
             n_checks, n_errors + n_end_err, wr_done, rd_done);
    if (n_errors + n_end_err == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule
